// File: logic/nocPkg.sv
package nocPkg;

  // number of sources that compete for this output port.
  localparam int numPorts = 5;

  // source indices, also the fixed priority order out of idle.
  localparam int portLocal = 0;
  localparam int portNorth = 1;
  localparam int portEast  = 2;
  localparam int portWest  = 3;
  localparam int portSouth = 4;

  // a flit is {kind, payload}, so the kind sits in the top bits.
  localparam int flitKindWidth = 3;
  localparam int payloadWidth  = 16;
  localparam int flitWidth     = flitKindWidth + payloadWidth;

  // a header carries its grant length in the low bits of the payload.
  localparam int lengthWidth = 12;

  localparam logic [flitKindWidth-1:0] kindHeader = 3'd1;
  localparam logic [flitKindWidth-1:0] kindBody   = 3'd2;
  localparam logic [flitKindWidth-1:0] kindTail   = 3'd3;

  // flits held per source.
  localparam int bufferDepth = 4;

  // bit 0 of the arbiter state is idle, bits 1 to numPorts are the grants.
  localparam logic [numPorts:0] stateIdle = 6'b000001;

endpackage

// File: logic/flitBuffer.sv
`timescale 1ns/10ps

module flitBuffer (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         inCyc,
  input  logic                         inStb,
  input  logic [nocPkg::flitWidth-1:0] inDat,
  output logic                         inAck,
  input  logic                         pop,
  output logic [nocPkg::flitWidth-1:0] headFlit,
  output logic                         notEmpty
);

  logic [nocPkg::flitWidth-1:0]             mem [nocPkg::bufferDepth];
  logic [$clog2(nocPkg::bufferDepth)-1:0]   wrPtr;
  logic [$clog2(nocPkg::bufferDepth)-1:0]   rdPtr;
  logic [$clog2(nocPkg::bufferDepth+1)-1:0] count;
  logic                                     full;
  logic                                     doWrite;
  logic                                     doPop;

  assign full     = (count == nocPkg::bufferDepth);
  assign notEmpty = (count != '0);
  assign headFlit = mem[rdPtr];

  // the source still holds its strobe during the ack cycle, so that cycle
  // must not take the same flit a second time.
  assign doWrite = inCyc && inStb && !inAck && !full;
  assign doPop   = pop && notEmpty;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inAck <= 1'b0;
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      inAck <= doWrite;
      if (doWrite)
      begin
        if (wrPtr == nocPkg::bufferDepth - 1)
          wrPtr <= '0;
        else
          wrPtr <= wrPtr + 1'b1;
      end
      if (doPop)
      begin
        if (rdPtr == nocPkg::bufferDepth - 1)
          rdPtr <= '0;
        else
          rdPtr <= rdPtr + 1'b1;
      end
      case ({doWrite, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= inDat;
  end

endmodule

// File: logic/packetTimer.sv
`timescale 1ns/10ps

module packetTimer (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           headerSent,
  input  logic [nocPkg::lengthWidth-1:0] headerLength,
  input  logic                           flitSent,
  input  logic                           granted,
  output logic                           timesUp
);

  logic [nocPkg::lengthWidth-1:0] limit;
  logic [nocPkg::lengthWidth-1:0] count;
  logic                           sentAny;

  // count holds the flits sent in this grant beyond the first one, so
  // a limit of L lets L+1 flits through before the grant is released.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit   <= '0;
      count   <= '0;
      sentAny <= 1'b0;
    end
    else
    begin
      if (headerSent)
        limit <= headerLength;
      if (!granted)
      begin
        count   <= '0;
        sentAny <= 1'b0;
      end
      else if (flitSent)
      begin
        sentAny <= 1'b1;
        if (headerSent)
          count <= '0;
        else if (sentAny)
          count <= count + 1'b1;
      end
    end
  end

  assign timesUp = sentAny && (count == limit);

endmodule

// File: logic/outputArbiter.sv
`timescale 1ns/10ps

module outputArbiter (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [nocPkg::numPorts-1:0]    request,
  input  logic [nocPkg::numPorts-1:0]    headerSent,
  input  logic [nocPkg::numPorts-1:0]    flitSent,
  input  logic [nocPkg::lengthWidth-1:0] headerLength,
  input  logic                           transferIdle,
  output logic [nocPkg::numPorts-1:0]    grant
);

  logic [nocPkg::numPorts:0]   state;
  logic [nocPkg::numPorts:0]   nextState;
  logic [nocPkg::numPorts-1:0] nextGrant;
  logic [nocPkg::numPorts-1:0] timesUp;

  for (genvar p = 0; p < nocPkg::numPorts; p++)
  begin : gTimer
    packetTimer timer (
      .clk          (clk),
      .rst          (rst),
      .headerSent   (headerSent[p]),
      .headerLength (headerLength),
      .flitSent     (flitSent[p]),
      .granted      (grant[p]),
      .timesUp      (timesUp[p])
    );
  end

  assign grant = state[nocPkg::numPorts:1];

  always_comb
  begin
    nextGrant = grant;
    if (transferIdle)
    begin
      nextGrant = '0;
      if (state == nocPkg::stateIdle)
      begin
        // out of idle the lowest index wins.
        for (int p = nocPkg::numPorts - 1; p >= 0; p--)
        begin
          if (request[p])
          begin
            nextGrant    = '0;
            nextGrant[p] = 1'b1;
          end
        end
      end
      else
      begin
        for (int h = 0; h < nocPkg::numPorts; h++)
        begin
          if (grant[h])
          begin
            if (request[h] && !timesUp[h])
              nextGrant = grant;
            else
            begin
              // search from the holder's successor, nearest one wins.
              for (int k = nocPkg::numPorts - 1; k >= 1; k--)
              begin
                if (request[(h + k) % nocPkg::numPorts])
                begin
                  nextGrant = '0;
                  nextGrant[(h + k) % nocPkg::numPorts] = 1'b1;
                end
              end
            end
          end
        end
      end
    end
  end

  assign nextState = {nextGrant, nextGrant == '0};

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= nocPkg::stateIdle;
    else
      state <= nextState;
  end

endmodule

// File: logic/routerOutputPort.sv
`timescale 1ns/10ps

module routerOutputPort (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [nocPkg::numPorts-1:0]  inCyc,
  input  logic [nocPkg::numPorts-1:0]  inStb,
  input  logic [nocPkg::flitWidth-1:0] inDat [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0]  inAck,
  output logic                         outCyc,
  output logic                         outStb,
  output logic [nocPkg::flitWidth-1:0] outDat,
  input  logic                         outAck
);

  logic [nocPkg::flitWidth-1:0]     headFlit [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0]      notEmpty;
  logic [nocPkg::numPorts-1:0]      grant;
  logic [nocPkg::numPorts-1:0]      flitSent;
  logic [nocPkg::numPorts-1:0]      headerSent;
  logic [nocPkg::flitKindWidth-1:0] outKind;
  logic                             transferIdle;
  logic                             ackSeen;

  for (genvar p = 0; p < nocPkg::numPorts; p++)
  begin : gBuffer
    flitBuffer buffer (
      .clk      (clk),
      .rst      (rst),
      .inCyc    (inCyc[p]),
      .inStb    (inStb[p]),
      .inDat    (inDat[p]),
      .inAck    (inAck[p]),
      .pop      (flitSent[p]),
      .headFlit (headFlit[p]),
      .notEmpty (notEmpty[p])
    );
  end

  outputArbiter arbiter (
    .clk          (clk),
    .rst          (rst),
    .request      (notEmpty),
    .headerSent   (headerSent),
    .flitSent     (flitSent),
    .headerLength (outDat[nocPkg::lengthWidth-1:0]),
    .transferIdle (transferIdle),
    .grant        (grant)
  );

  always_comb
  begin
    outDat = '0;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      if (grant[p])
        outDat = headFlit[p];
    end
  end

  assign outKind    = outDat[nocPkg::flitWidth-1 -: nocPkg::flitKindWidth];
  assign flitSent   = grant & {nocPkg::numPorts{outStb && outAck}};
  assign headerSent = flitSent & {nocPkg::numPorts{outKind == nocPkg::kindHeader}};

  // the grant cannot move while a strobe is out, so outDat stays put.
  assign transferIdle = !outStb;
  assign outCyc       = |grant;

  // after each accepted flit the strobe rests one cycle while the arbiter
  // looks at the updated timers, then one more so a new grant settles first.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outStb  <= 1'b0;
      ackSeen <= 1'b0;
    end
    else
    begin
      ackSeen <= outStb && outAck;
      if (outStb)
      begin
        if (outAck)
          outStb <= 1'b0;
      end
      else if (!ackSeen && |(grant & notEmpty))
        outStb <= 1'b1;
    end
  end

endmodule

// File: test/outputPortChecker.sv
`timescale 1ns/10ps

module outputPortChecker (
  input logic                         clk,
  input logic                         rst,
  input logic                         outCyc,
  input logic                         outStb,
  input logic                         outAck,
  input logic [nocPkg::flitWidth-1:0] outDat,
  input logic [nocPkg::numPorts-1:0]  grant
);

  logic [nocPkg::flitWidth-1:0] expected [nocPkg::numPorts][$];
  int srcLog [$];
  int errors = 0;
  int testErrors = 0;
  int testCount = 0;
  bit wholePackets = 1'b0;
  int openSrc = -1;

  task automatic expectFlit(input int src, input logic [nocPkg::flitWidth-1:0] flit);
    expected[src].push_back(flit);
  endtask

  function automatic int pending();
    int total;
    total = 0;
    for (int p = 0; p < nocPkg::numPorts; p++)
      total += expected[p].size();
    return total;
  endfunction

  task automatic scenarioFail(input string msg);
    $display("%0t ns: %s", $time, msg);
    errors++;
    testErrors++;
  endtask

  // the arbitration tests name the source expected at a position of the log.
  task automatic checkSource(input int pos, input int src);
    if (pos >= srcLog.size())
      scenarioFail($sformatf("only %0d flits reached the output, flit %0d is missing",
                             srcLog.size(), pos));
    else if (srcLog[pos] != src)
    begin
      $display("CHECK FAILED at %0t ns: srcLog[%0d] expected %0d, got %0d",
               $time, pos, src, srcLog[pos]);
      errors++;
      testErrors++;
    end
  endtask

  task automatic reportTest(input string name);
    testCount++;
    $display("test %0d %s: %s, %0d errors", testCount, name,
             (testErrors == 0) ? "ok" : "failing", testErrors);
    testErrors = 0;
  endtask

  // a wishbone strobe is only valid inside a cycle.
  always @(posedge clk)
  begin
    if (!rst && outStb && outCyc !== 1'b1)
    begin
      $display("CHECK FAILED at %0t ns: outCyc expected 1, got %b", $time, outCyc);
      errors++;
      testErrors++;
    end
  end

  // every flit accepted on the link is matched against its source's queue.
  always @(posedge clk)
  begin : acceptFlit
    int src;
    logic [nocPkg::flitKindWidth-1:0] kind;
    logic [nocPkg::flitWidth-1:0] want;
    if (!rst && outStb && outAck)
    begin
      src = -1;
      for (int p = 0; p < nocPkg::numPorts; p++)
        if (grant[p])
          src = p;
      kind = outDat[nocPkg::flitWidth-1 -: nocPkg::flitKindWidth];
      if (src < 0)
        scenarioFail("a flit was accepted while no source held the grant");
      else if (expected[src].size() == 0)
        scenarioFail($sformatf("source %0d sent a flit that was never written", src));
      else
      begin
        want = expected[src].pop_front();
        srcLog.push_back(src);
        if (outDat !== want)
        begin
          $display("CHECK FAILED at %0t ns: outDat (source %0d) expected %h, got %h",
                   $time, src, want, outDat);
          errors++;
          testErrors++;
        end
        if (wholePackets && openSrc >= 0 && src != openSrc)
          scenarioFail($sformatf("source %0d cut into the open packet of source %0d",
                                 src, openSrc));
        if (kind == nocPkg::kindHeader)
          openSrc = src;
        else if (kind == nocPkg::kindTail)
          openSrc = -1;
      end
    end
  end

endmodule

// File: test/outputArbiter_assert.sv
`timescale 1ns/10ps

module portAssertions (
  input logic                         clk,
  input logic                         rst,
  input logic [nocPkg::numPorts-1:0]  grant,
  input logic                         outStb,
  input logic                         outAck,
  input logic [nocPkg::flitWidth-1:0] outDat
);

  logic [nocPkg::numPorts:0] stateWord;
  int failCount = 0;

  assign stateWord = {grant, grant == '0};

  assert property (@(posedge clk) rst |=> stateWord == nocPkg::stateIdle)
    else
    begin
      failCount++;
      $error("arbiter is not idle after reset");
    end

  assert property (@(posedge clk) disable iff (rst) $onehot(stateWord))
    else
    begin
      failCount++;
      $error("arbiter state is not one-hot");
    end

  assert property (@(posedge clk) disable iff (rst) outStb && !outAck |=> $stable(grant))
    else
    begin
      failCount++;
      $error("grant moved while a strobe was pending");
    end

  assert property (@(posedge clk) disable iff (rst) outStb && !outAck |=> $stable(outDat))
    else
    begin
      failCount++;
      $error("outDat changed during a stall");
    end

endmodule

bind routerOutputPort portAssertions u_assert (
  .clk    (clk),
  .rst    (rst),
  .grant  (grant),
  .outStb (outStb),
  .outAck (outAck),
  .outDat (outDat)
);

// File: test/tbRouterOutputPort.sv
`timescale 1ns/10ps

module tbRouterOutputPort;

  localparam int totalFlits  = 147;
  localparam int maxAckDelay = 4;
  localparam int cycleLimit  = 4 * totalFlits * maxAckDelay + 200;

  logic                         clk;
  logic                         rst;
  logic [nocPkg::numPorts-1:0]  inCyc;
  logic [nocPkg::numPorts-1:0]  inStb;
  logic [nocPkg::flitWidth-1:0] inDat [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0]  inAck;
  logic                         outCyc;
  logic                         outStb;
  logic [nocPkg::flitWidth-1:0] outDat;
  logic                         outAck;

  logic [31:0] rngState;
  int gapMax;
  int ackDelayMax;
  int ackWait;
  bit ackHold;
  int cycles;
  int maxWait;
  int seqNum [nocPkg::numPorts];
  int start;
  int totalErrors;
  logic [nocPkg::flitWidth-1:0] sendQ [nocPkg::numPorts][$];

  routerOutputPort u_dut (
    .clk    (clk),
    .rst    (rst),
    .inCyc  (inCyc),
    .inStb  (inStb),
    .inDat  (inDat),
    .inAck  (inAck),
    .outCyc (outCyc),
    .outStb (outStb),
    .outDat (outDat),
    .outAck (outAck)
  );

  outputPortChecker monitor (
    .clk    (clk),
    .rst    (rst),
    .outCyc (outCyc),
    .outStb (outStb),
    .outAck (outAck),
    .outDat (outDat),
    .grant  (u_dut.grant)
  );

  function automatic logic [31:0] xorshift();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  // headers keep the length in the low bits, the rest carry a sequence number.
  function automatic logic [nocPkg::flitWidth-1:0] expectedFlit(input int src, input int index,
      input logic [nocPkg::flitKindWidth-1:0] kind, input int length);
    logic [nocPkg::payloadWidth-1:0] payload;
    logic [2:0] srcBits;
    logic [12:0] indexBits;
    logic [nocPkg::lengthWidth-1:0] lengthBits;
    srcBits    = src[2:0];
    indexBits  = index[12:0];
    lengthBits = length[nocPkg::lengthWidth-1:0];
    if (kind == nocPkg::kindHeader)
      payload = {srcBits, indexBits[0], lengthBits};
    else
      payload = {srcBits, indexBits};
    return {kind, payload};
  endfunction

  task automatic queuePacket(input int src, input int size, input int length);
    logic [nocPkg::flitKindWidth-1:0] kind;
    logic [nocPkg::flitWidth-1:0] flit;
    for (int i = 0; i < size; i++)
    begin
      if (i == 0)
        kind = nocPkg::kindHeader;
      else if (i == size - 1)
        kind = nocPkg::kindTail;
      else
        kind = nocPkg::kindBody;
      flit = expectedFlit(src, seqNum[src], kind, length);
      seqNum[src]++;
      sendQ[src].push_back(flit);
      monitor.expectFlit(src, flit);
    end
  endtask

  function automatic int unsent();
    int total;
    total = 0;
    for (int p = 0; p < nocPkg::numPorts; p++)
      total += sendQ[p].size();
    return total;
  endfunction

  task automatic waitDrained();
    while (unsent() > 0 || monitor.pending() > 0)
      @(posedge clk);
    repeat (10) @(posedge clk);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycleLimit)
    begin
      $display("timeout after %0d cycles, %0d flits never reached the output",
               cycles, monitor.pending());
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // downstream slave with a random acknowledge delay.
  always @(posedge clk)
  begin
    if (rst || outAck)
      outAck <= 1'b0;
    else if (outStb && !ackHold)
    begin
      if (ackWait == 0)
      begin
        outAck  <= 1'b1;
        ackWait = (ackDelayMax > 0) ? xorshift() % (ackDelayMax + 1) : 0;
      end
      else
        ackWait--;
    end
  end

  for (genvar p = 0; p < nocPkg::numPorts; p++)
  begin : gSource
    initial
    begin
      logic [nocPkg::flitWidth-1:0] flit;
      int gap;
      int waitCycles;
      forever
      begin
        @(posedge clk);
        if (!rst && sendQ[p].size() > 0)
        begin
          flit = sendQ[p].pop_front();
          gap = (gapMax > 0) ? xorshift() % (gapMax + 1) : 0;
          repeat (gap) @(posedge clk);
          inCyc[p] <= 1'b1;
          inStb[p] <= 1'b1;
          inDat[p] <= flit;
          waitCycles = 0;
          do
          begin
            @(posedge clk);
            waitCycles++;
          end
          while (!inAck[p]);
          if (waitCycles > maxWait)
            maxWait = waitCycles;
          inCyc[p] <= 1'b0;
          inStb[p] <= 1'b0;
        end
      end
    end
  end

  initial
  begin
    rst = 1'b1;
    inCyc = '0;
    inStb = '0;
    outAck = 1'b0;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      inDat[p] = '0;
      seqNum[p] = 0;
    end
    rngState = 32'd96162;
    gapMax = 3;
    ackDelayMax = 0;
    ackWait = 0;
    ackHold = 1'b0;
    cycles = 0;
    maxWait = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    for (int s = 0; s < nocPkg::numPorts; s++)
    begin
      queuePacket(s, 3, 3);
      queuePacket(s, 3, 3);
    end
    waitDrained();
    monitor.reportTest("per-source order");

    // buffers are preloaded behind a stalled link so no packet starves.
    @(negedge clk);
    gapMax = 0;
    ackHold = 1'b1;
    monitor.wholePackets = 1'b1;
    for (int s = 0; s < nocPkg::numPorts; s++)
    begin
      queuePacket(s, 3, 3);
      queuePacket(s, 3, 3);
    end
    repeat (20) @(posedge clk);
    @(negedge clk);
    ackHold = 1'b0;
    waitDrained();
    monitor.wholePackets = 1'b0;
    monitor.reportTest("whole packets");

    // with a limit of 2 the local source sends 3 flits, then north is next in turn.
    @(negedge clk);
    start = monitor.srcLog.size();
    ackHold = 1'b1;
    queuePacket(nocPkg::portLocal, 8, 2);
    queuePacket(nocPkg::portNorth, 2, 5);
    repeat (20) @(posedge clk);
    @(negedge clk);
    ackHold = 1'b0;
    waitDrained();
    for (int i = 0; i < 3; i++)
      monitor.checkSource(start + i, nocPkg::portLocal);
    monitor.checkSource(start + 3, nocPkg::portNorth);
    monitor.reportTest("timeout split");

    @(negedge clk);
    start = monitor.srcLog.size();
    ackHold = 1'b1;
    for (int r = 0; r < 3; r++)
      for (int s = 0; s < nocPkg::numPorts; s++)
        queuePacket(s, 1, 0);
    repeat (30) @(posedge clk);
    @(negedge clk);
    ackHold = 1'b0;
    waitDrained();
    for (int i = 0; i < 15; i++)
      monitor.checkSource(start + i, i % nocPkg::numPorts);
    monitor.reportTest("rotating priority");

    repeat (20) @(posedge clk);
    @(negedge clk);
    start = monitor.srcLog.size();
    queuePacket(nocPkg::portWest, 1, 0);
    queuePacket(nocPkg::portNorth, 1, 0);
    waitDrained();
    monitor.checkSource(start, nocPkg::portNorth);
    monitor.checkSource(start + 1, nocPkg::portWest);
    monitor.reportTest("fixed priority from idle");

    @(negedge clk);
    gapMax = 3;
    ackDelayMax = maxAckDelay;
    maxWait = 0;
    for (int r = 0; r < 3; r++)
      for (int s = 0; s < nocPkg::numPorts; s++)
        queuePacket(s, 4, 4);
    waitDrained();
    if (maxWait <= 2)
      monitor.scenarioFail("no input was ever stalled by a full buffer");
    monitor.reportTest("back-pressure");

    totalErrors = monitor.errors + u_dut.u_assert.failCount;
    $display("%0d tests run, %0d errors", monitor.testCount, totalErrors);
    if (totalErrors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: sim.f
logic/nocPkg.sv
logic/flitBuffer.sv
logic/packetTimer.sv
logic/outputArbiter.sv
logic/routerOutputPort.sv
test/outputPortChecker.sv
test/outputArbiter_assert.sv
test/tbRouterOutputPort.sv

// File: Bender.yml
package:
  name: router_output_port

sources:
  - logic/nocPkg.sv
  - logic/flitBuffer.sv
  - logic/packetTimer.sv
  - logic/outputArbiter.sv
  - logic/routerOutputPort.sv
  - target: simulation
    files:
      - test/outputPortChecker.sv
      - test/outputArbiter_assert.sv
      - test/tbRouterOutputPort.sv
